//--- design/budgetBank.sv
module budgetBank #(
  parameter int defaultBudget = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  flitPkg::flitT      flitIn [portPkg::portCount],
  input  portPkg::portIndex  holder,
  input  logic               restart,
  input  logic               accept,
  output portPkg::portMask   exhausted
);

  // --------------------
  // One limit and one count per port
  // --------------------
  for (genvar p = 0; p < portPkg::portCount; p++)
  begin : gPort
    flitPkg::flitLength limit;      // Length of the last header this port sent
    flitPkg::flitLength count;      // Flits accepted since the hold began
    flitPkg::flitLength freshCount; // Count as seen in this cycle
    logic held;
    logic acceptHere;
    logic headerHere;

    assign held       = (holder == portPkg::portIndex'(p));
    assign acceptHere = accept && held;
    assign headerHere = acceptHere && (flitIn[p].kind == flitPkg::headKind);

    // A hold that starts in this cycle sees an empty count right away
    assign freshCount = (restart && held) ? '0 : count;

    assign exhausted[p] = (freshCount >= limit);

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        limit <= flitPkg::flitLength'(defaultBudget);
        count <= '0;
      end
      else
      begin
        if (headerHere)
        begin
          // A zero length would never let the port send, so it counts as one
          if (flitIn[p].length == '0)
          begin
            limit <= flitPkg::flitLength'(1);
          end
          else
          begin
            limit <= flitIn[p].length;
          end
        end
        count <= freshCount + flitPkg::flitLength'(acceptHere);
      end
    end

    // Only the port holding the output can run out of budget
    assert property (@(posedge clk) disable iff (rst)
      $rose(exhausted[p]) |-> held)
    else
      $error("Port %0d ran out of budget while port %0d held the output", p, holder);
  end

endmodule

//--- design/flitPkg.sv
package flitPkg;

  // --------------------
  // Flit role codes
  // --------------------
  typedef logic [2:0] flitKind;

  localparam flitKind headKind = 3'd1; // Opens a packet and carries its length
  localparam flitKind bodyKind = 3'd2;
  localparam flitKind tailKind = 3'd3;

  // Packet length in flits as carried by a header
  typedef logic [11:0] flitLength;

  typedef logic [15:0] flitPayload;

  // --------------------
  // Flit as it travels on the link
  // --------------------
  typedef struct packed {
    flitKind    kind;
    flitLength  length;  // Only meaningful on a header
    flitPayload payload;
  } flitT;

endpackage

//--- design/grantControl.sv
module grantControl (
  input  logic               clk,
  input  logic               rst,
  input  portPkg::portMask   req,
  input  flitPkg::flitT      flitIn [portPkg::portCount],
  input  portPkg::portIndex  pick,
  input  logic               anyReq,
  input  portPkg::portMask   exhausted,
  input  logic               ack,
  output portPkg::portIndex  holder,
  output portPkg::portIndex  lastHolder,
  output logic               restart,
  output logic               accept,
  output logic               cyc,
  output logic               stb,
  output flitPkg::flitT      dat,
  output portPkg::portMask   taken
);

  portPkg::grantState state;
  portPkg::grantState nextState;
  portPkg::portIndex  holderReg;
  portPkg::portIndex  nextHolder;
  logic               startHold; // A new hold begins at the next edge
  logic               holding;

  // --------------------
  // Wishbone master side
  // --------------------
  assign holding = (state == portPkg::holdState);

  // The held port sends while it asks and still has budget
  assign stb = holding && req[holderReg] && !exhausted[holderReg];
  assign cyc = stb; // Every transfer is a single write

  assign dat    = flitIn[holderReg];
  assign accept = stb && ack;

  // Tell the held port its flit is gone in the same cycle as ack
  assign taken = accept ? (portPkg::portMask'(1) << holderReg) : '0;

  // --------------------
  // Grant decision
  // --------------------
  always_comb
  begin
    nextState  = state;
    nextHolder = holderReg;
    startHold  = 1'b0;
    // Arbitrate when idle or when the held port stops sending
    if (!holding || !stb)
    begin
      if (anyReq)
      begin
        nextState  = portPkg::holdState;
        nextHolder = pick;
        startHold  = 1'b1;
      end
      else
      begin
        nextState = portPkg::idleState;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= portPkg::idleState;
      holderReg <= portPkg::southPort; // So local is searched first
      restart   <= 1'b0;
    end
    else
    begin
      state     <= nextState;
      holderReg <= nextHolder;
      restart   <= startHold;
    end
  end

  // The search resumes after whoever held the output last
  assign holder     = holderReg;
  assign lastHolder = holderReg;

  // --------------------
  // Checks
  // --------------------
  // A write offered on the bus stays put until the sink takes it
  assert property (@(posedge clk) disable iff (rst)
    stb && !ack |=> stb && $stable(dat))
  else
    $error("Write from port %0d withdrawn or changed before ack", holderReg);

  assert property (@(posedge clk) disable iff (rst)
    $onehot0(taken))
  else
    $error("More than one port sees taken, %b", taken);

endmodule

//--- design/outputPort.sv
module outputPort #(
  parameter int defaultBudget = 4 // Budget of a port before its first header
) (
  input  logic              clk,
  input  logic              rst,
  input  portPkg::portMask  req,
  input  flitPkg::flitT     flitIn [portPkg::portCount],
  input  logic              ack,
  output portPkg::portMask  taken,
  output logic              cyc,
  output logic              stb,
  output flitPkg::flitT     dat
);

  portPkg::portIndex holder;
  portPkg::portIndex lastHolder;
  portPkg::portIndex pick;
  portPkg::portMask  exhausted;
  logic              restart;
  logic              accept;
  logic              anyReq;

  // --------------------
  // Budget and priority run side by side
  // --------------------
  budgetBank #(
    .defaultBudget(defaultBudget)
  ) budget (
    .clk      (clk),
    .rst      (rst),
    .flitIn   (flitIn),
    .holder   (holder),
    .restart  (restart),
    .accept   (accept),
    .exhausted(exhausted)
  );

  rotatePriority rotate (
    .req       (req),
    .lastHolder(lastHolder),
    .pick      (pick),
    .anyReq    (anyReq)
  );

  // Combines both results and drives the bus
  grantControl grant (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .flitIn    (flitIn),
    .pick      (pick),
    .anyReq    (anyReq),
    .exhausted (exhausted),
    .ack       (ack),
    .holder    (holder),
    .lastHolder(lastHolder),
    .restart   (restart),
    .accept    (accept),
    .cyc       (cyc),
    .stb       (stb),
    .dat       (dat),
    .taken     (taken)
  );

endmodule

//--- design/portPkg.sv
package portPkg;

  // --------------------
  // Router ports
  // --------------------
  localparam int portCount = 5;

  // Local 0, north 1, east 2, west 3, south 4
  typedef logic [2:0] portIndex;

  localparam portIndex localPort = 3'd0;
  localparam portIndex northPort = 3'd1;
  localparam portIndex eastPort  = 3'd2;
  localparam portIndex westPort  = 3'd3;
  localparam portIndex southPort = 3'd4;

  // One bit per port, bit i belongs to port i
  typedef logic [portCount-1:0] portMask;

  // --------------------
  // Grant state machine
  // --------------------
  typedef enum logic {
    idleState, // No port holds the output
    holdState  // One port holds the output and may send
  } grantState;

endpackage

//--- design/rotatePriority.sv
module rotatePriority (
  input  portPkg::portMask   req,
  input  portPkg::portIndex  lastHolder,
  output portPkg::portIndex  pick,
  output logic               anyReq
);

  // --------------------
  // Round-robin search
  // --------------------
  // Steps run from the farthest port down to the nearest one so that the
  // port right after lastHolder wins, and lastHolder itself comes last
  always_comb
  begin
    int unsigned candidate;

    pick   = lastHolder;
    anyReq = 1'b0;
    for (int step = portPkg::portCount; step >= 1; step--)
    begin
      candidate = (int'(lastHolder) + step) % portPkg::portCount;
      if (req[candidate])
      begin
        pick   = portPkg::portIndex'(candidate);
        anyReq = 1'b1;
      end
    end
  end

  // The picked port must be one that asks for the output
  always_comb
  begin
    assert final (!anyReq || req[pick])
    else
      $error("Picked port %0d is not requesting, req %b", pick, req);
  end

endmodule

//--- sim.f
design/flitPkg.sv
design/portPkg.sv
design/budgetBank.sv
design/rotatePriority.sv
design/grantControl.sv
design/outputPort.sv
test/outputPortTb.sv

//--- test/outputPortTb.sv
module outputPortTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int defaultBudget = 4;
  localparam int resetCycles   = 10;
  localparam int idleCycles    = 20;
  localparam int queuedFlits   = 48; // Over all six tests
  // Every test resets and ends with a few quiet cycles
  localparam int cycleLimit    = queuedFlits * 20 + 6 * (resetCycles + 5) + idleCycles + 100;

  logic             clk;
  logic             rst;
  portPkg::portMask req;
  flitPkg::flitT    flitIn [portPkg::portCount];
  logic             ack;
  portPkg::portMask taken;
  logic             cyc;
  logic             stb;
  flitPkg::flitT    dat;

  flitPkg::flitT portQueue [portPkg::portCount][$]; // Flits each port still has to send
  flitPkg::flitT expFlit[$];
  int            expPort[$];
  int            modelLimit [portPkg::portCount];
  int            modelLast;

  integer        seed = 32'h7eb6;
  int            ackDelay;
  logic          randomAck;
  logic          prevStall;
  flitPkg::flitT prevDat;
  string         testName;
  int            valueErrors = 0;
  int            protocolErrors = 0;
  int            cycleCount = 0;

  outputPort #(
    .defaultBudget(defaultBudget)
  ) DUT (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .flitIn(flitIn),
    .ack   (ack),
    .taken (taken),
    .cyc   (cyc),
    .stb   (stb),
    .dat   (dat)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout in %s after %0d cycles, flits were still waiting", testName, cycleCount);
      $display("Checks failed");
      $finish;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic reportMismatch(string what, logic [31:0] expected, logic [31:0] actual);
    valueErrors++;
    $display("Fail %s %s: expected %0h, actual %0h", testName, what, expected, actual);
  endtask

  task automatic reportProblem(string text);
    protocolErrors++;
    $display("Error in %s: %s", testName, text);
  endtask

  task automatic queueFlit(int port, flitPkg::flitKind kind, int length);
    flitPkg::flitT f;
    f.kind    = kind;
    f.length  = flitPkg::flitLength'(length);
    f.payload = flitPkg::flitPayload'(port * 256 + portQueue[port].size()); // Unique per test
    portQueue[port].push_back(f);
  endtask

  // Header of the given length, then extra flits of which the last is a tail
  task automatic queuePacket(int port, int length, int extra);
    queueFlit(port, flitPkg::headKind, length);
    for (int i = 1; i <= extra; i++)
      queueFlit(port, (i == extra) ? flitPkg::tailKind : flitPkg::bodyKind, 0);
  endtask

  function automatic int nextInRotation(portPkg::portMask pending, int last);
    int candidate;
    for (int step = 1; step <= portPkg::portCount; step++)
    begin
      candidate = (last + step) % portPkg::portCount;
      if (pending[candidate])
        return candidate;
    end
    return last;
  endfunction

  // Applies the grant, rotation and budget rules at flit level to the queued flits
  task automatic predictOrder();
    flitPkg::flitT    work [portPkg::portCount][$];
    flitPkg::flitT    f;
    portPkg::portMask pending;
    int               held;
    int               sent;
    for (int p = 0; p < portPkg::portCount; p++)
      work[p] = portQueue[p];
    forever
    begin
      for (int p = 0; p < portPkg::portCount; p++)
        pending[p] = (work[p].size() > 0);
      if (pending == '0)
        break;
      held = nextInRotation(pending, modelLast);
      sent = 0; // Every new hold starts with a fresh count
      while (work[held].size() > 0 && sent < modelLimit[held])
      begin
        f = work[held].pop_front();
        expPort.push_back(held);
        expFlit.push_back(f);
        if (f.kind == flitPkg::headKind)
          modelLimit[held] = (f.length == 0) ? 1 : int'(f.length);
        sent++;
      end
      modelLast = held;
    end
  endtask

  task automatic resetDut();
    @(negedge clk);
    rst = 1'b1;
    req = '0;
    ack = 1'b0;
    repeat (resetCycles) @(negedge clk);
    rst = 1'b0;
    for (int p = 0; p < portPkg::portCount; p++)
    begin
      portQueue[p].delete();
      modelLimit[p] = defaultBudget;
    end
    modelLast = portPkg::southPort; // Local is searched first after reset
    expPort.delete();
    expFlit.delete();
    prevStall = 1'b0;
    ackDelay  = 0;
  endtask

  // --------------------
  // One cycle of ports and sink
  // --------------------
  task automatic runCycle();
    logic accepted;
    int   port;
    @(negedge clk);
    for (int p = 0; p < portPkg::portCount; p++)
    begin
      req[p]    = (portQueue[p].size() > 0);
      flitIn[p] = req[p] ? portQueue[p][0] : '0;
    end
    ack = !randomAck || (ackDelay == 0);
    #1; // Outputs have settled well before the rising edge
    accepted = (stb === 1'b1) && ack;
    if (cyc !== stb)
      reportProblem("cyc does not follow stb");
    if (prevStall && (stb !== 1'b1 || dat !== prevDat))
      reportProblem("the write was withdrawn or changed before ack");
    if (!accepted && taken !== '0)
      reportProblem("taken pulsed without an accepted write");
    if (accepted)
    begin
      port = -1;
      for (int p = 0; p < portPkg::portCount; p++)
        if (taken == portPkg::portMask'(1 << p))
          port = p;
      if (port < 0)
        reportProblem($sformatf("taken is %b for an accepted write", taken));
      else if (expPort.size() == 0)
        reportProblem("a flit was accepted beyond the predicted sequence");
      else
      begin
        if (port != expPort[0])
          reportMismatch("port", expPort[0], port);
        if (dat !== expFlit[0])
          reportMismatch("flit", expFlit[0], dat);
        void'(expPort.pop_front());
        void'(expFlit.pop_front());
        void'(portQueue[port].pop_front());
      end
      if (randomAck)
        ackDelay = $unsigned($random(seed)) % 4;
    end
    else if (stb === 1'b1 && ackDelay > 0)
      ackDelay--;
    prevStall = (stb === 1'b1) && !ack;
    prevDat   = dat;
  endtask

  task automatic drainQueues();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      runCycle();
      busy = 1'b0;
      for (int p = 0; p < portPkg::portCount; p++)
        if (portQueue[p].size() > 0)
          busy = 1'b1;
    end
    repeat (3) runCycle(); // Catches late or repeated taken pulses
    if (expPort.size() != 0)
      reportProblem($sformatf("%0d predicted flits never arrived", expPort.size()));
  endtask

  task automatic expectIdle();
    if (cyc !== 1'b0)
      reportMismatch("cyc", 0, cyc);
    if (stb !== 1'b0)
      reportMismatch("stb", 0, stb);
    if (taken !== '0)
      reportMismatch("taken", 0, taken);
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic testIdleAfterReset();
    testName = "idleAfterReset";
    resetDut();
    #1;
    expectIdle();
    repeat (idleCycles)
    begin
      runCycle();
      expectIdle();
    end
  endtask

  task automatic testSinglePort();
    testName = "singlePort";
    resetDut();
    queuePacket(portPkg::northPort, 3, 2);
    predictOrder();
    drainQueues();
  endtask

  task automatic testAllPorts();
    testName = "allPorts";
    resetDut();
    queuePacket(0, 2, 1);
    queuePacket(0, 2, 1);
    queuePacket(1, 3, 2);
    queuePacket(1, 1, 0);
    queuePacket(2, 0, 0); // Zero length still lets one flit through
    queuePacket(2, 1, 0);
    repeat (4) queueFlit(3, flitPkg::bodyKind, 0); // Sent under the default budget
    queuePacket(3, 2, 1);
    queuePacket(4, 3, 2);
    predictOrder();
    drainQueues();
  endtask

  task automatic testEarlyRelease();
    testName = "earlyRelease";
    resetDut();
    queuePacket(portPkg::localPort, 4, 1);
    queuePacket(portPkg::eastPort, 2, 1);
    queuePacket(portPkg::southPort, 2, 1);
    predictOrder();
    drainQueues();
  endtask

  task automatic testSoleRequester();
    testName = "soleRequester";
    resetDut();
    queuePacket(portPkg::southPort, 2, 4);
    predictOrder();
    drainQueues();
  endtask

  task automatic testRandomAck();
    testName = "randomAck";
    resetDut();
    randomAck = 1'b1;
    ackDelay  = $unsigned($random(seed)) % 4;
    for (int p = 0; p < portPkg::portCount; p++)
      queuePacket(p, p % 3 + 1, 2);
    predictOrder();
    drainQueues();
    randomAck = 1'b0;
  endtask

  initial
  begin
    rst       = 1'b1;
    req       = '0;
    ack       = 1'b0;
    randomAck = 1'b0;
    prevStall = 1'b0;
    prevDat   = '0;
    ackDelay  = 0;
    testName  = "startup";
    for (int p = 0; p < portPkg::portCount; p++)
      flitIn[p] = '0;
    testIdleAfterReset();
    testSinglePort();
    testAllPorts();
    testEarlyRelease();
    testSoleRequester();
    testRandomAck();
    $display("Errors: %0d value mismatches, %0d protocol problems", valueErrors, protocolErrors);
    if (valueErrors + protocolErrors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
